// File: Bender.yml
package:
  name: serial_slave

sources:
  - hw/serial_slave_pkg.sv
  - hw/serial_deserializer.sv
  - hw/word_serializer.sv
  - hw/slave_controller.sv
  - hw/serial_slave_top.sv
  - target: simulation
    files:
      - sim/serial_slave_asserts.sv
      - sim/tb_serial_slave.sv

// File: hw/serial_deserializer.sv
`timescale 1ns/10ps
/*
 * serial to parallel shift register
 * collects one payload of any packed type msb first,
 * pulses word_done the cycle after the final bit
 */
module serial_deserializer #(
    parameter type payload_t = serial_slave_pkg::word_t
) (
    input  logic     clk,
    input  logic     rstN,
    input  logic     bit_in,
    input  logic     shift_en,
    output payload_t word,
    output logic     word_done
);

    logic [$bits(payload_t)-1:0]           shreg;
    logic [$clog2($bits(payload_t)+1)-1:0] bit_cnt;
    logic                                  cnt_full;

    // this enabled bit completes the payload
    assign cnt_full = (bit_cnt == $bits(payload_t) - 1);

    // new bits enter at the low end, so the first bit ends up as msb
    always_ff @(posedge clk) begin
        if (shift_en) begin
            shreg <= {shreg[$bits(payload_t)-2:0], bit_in};
        end
    end

    // count wraps to zero on the last bit, next word may follow at once
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bit_cnt   <= '0;
            word_done <= 1'b0;
        end else begin
            word_done <= shift_en && cnt_full;
            if (shift_en) begin
                if (cnt_full) begin
                    bit_cnt <= '0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    assign word = payload_t'(shreg);

endmodule

// File: hw/serial_slave_pkg.sv
/*
 * shared definitions of the serial bus slave
 * memory geometry, slave id width and start code,
 * command frame layout and the bus line structs
 */
package serial_slave_pkg;

    // data memory geometry
    localparam int DATA_WIDTH = 8;
    localparam int ADDR_WIDTH = 4;
    localparam int MEM_DEPTH  = 16;

    // command frame fields
    localparam int         SID_WIDTH  = 2;
    localparam logic [2:0] START_CODE = 3'b111;

    // start code, slave id, write flag, burst flag, address
    localparam int CMD_BITS = 3 + SID_WIDTH + 2 + ADDR_WIDTH;

    typedef logic [DATA_WIDTH-1:0] word_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [SID_WIDTH-1:0]  sid_t;

    // fields in the order they arrive on control, msb first
    typedef struct packed {
        logic [2:0] start;
        sid_t       slave_id;
        logic       write;
        logic       burst;
        addr_t      addr;
    } cmd_frame_t;

    // master to slave lines
    typedef struct packed {
        logic control;
        logic wd;
        logic valid;
        logic last;
    } bus_in_t;

    // slave to master lines
    typedef struct packed {
        logic rd;
        logic ready;
    } bus_out_t;

endpackage

// File: hw/serial_slave_top.sv
`timescale 1ns/10ps
/*
 * top level of the serial bus slave
 * command frame and write data deserializers,
 * transfer controller and read data serializer
 */
module serial_slave_top #(
    parameter serial_slave_pkg::sid_t SLAVE_ID = 2'd1
) (
    input  logic                       clk,
    input  logic                       rstN,
    input  serial_slave_pkg::bus_in_t  bus_in,
    output serial_slave_pkg::bus_out_t bus_out
);
    import serial_slave_pkg::*;

    cmd_frame_t frame;
    logic       frame_done;
    logic       frame_shift;
    word_t      wr_word;
    logic       wr_done;
    logic       wr_shift;
    logic       rd_load;
    word_t      rd_word;
    logic       rd_busy;

    // command frame from the control line
    serial_deserializer #(
        .payload_t (cmd_frame_t)
    ) u_frame_rx (
        .clk       (clk),
        .rstN      (rstN),
        .bit_in    (bus_in.control),
        .shift_en  (frame_shift),
        .word      (frame),
        .word_done (frame_done)
    );

    // write words from wd
    serial_deserializer #(
        .payload_t (word_t)
    ) u_wdata_rx (
        .clk       (clk),
        .rstN      (rstN),
        .bit_in    (bus_in.wd),
        .shift_en  (wr_shift),
        .word      (wr_word),
        .word_done (wr_done)
    );

    slave_controller #(
        .SLAVE_ID (SLAVE_ID)
    ) u_ctrl (
        .clk         (clk),
        .rstN        (rstN),
        .control     (bus_in.control),
        .valid       (bus_in.valid),
        .last        (bus_in.last),
        .frame       (frame),
        .frame_done  (frame_done),
        .frame_shift (frame_shift),
        .wr_word     (wr_word),
        .wr_done     (wr_done),
        .wr_shift    (wr_shift),
        .rd_load     (rd_load),
        .rd_word     (rd_word),
        .rd_busy     (rd_busy),
        .ready       (bus_out.ready)
    );

    // read words onto rd
    word_serializer u_rdata_tx (
        .clk     (clk),
        .rstN    (rstN),
        .load    (rd_load),
        .word    (rd_word),
        .bit_out (bus_out.rd),
        .busy    (rd_busy)
    );

endmodule

// File: hw/slave_controller.sv
`timescale 1ns/10ps
/*
 * transfer controller of the serial bus slave
 * transfer FSM, command check, address counter,
 * data memory and ready generation
 */
module slave_controller #(
    parameter serial_slave_pkg::sid_t SLAVE_ID = 2'd1
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         control,
    input  logic                         valid,
    input  logic                         last,
    input  serial_slave_pkg::cmd_frame_t frame,
    input  logic                         frame_done,
    output logic                         frame_shift,
    input  serial_slave_pkg::word_t      wr_word,
    input  logic                         wr_done,
    output logic                         wr_shift,
    output logic                         rd_load,
    output serial_slave_pkg::word_t      rd_word,
    input  logic                         rd_busy,
    output logic                         ready
);
    import serial_slave_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FRAME,
        ST_CHECK,
        ST_WRITE,
        ST_RD_FETCH,
        ST_RD_SEND,
        ST_RD_ACK
    } state_t;

    state_t state;
    addr_t  addr;
    logic   last_seen;
    logic   frame_ok;
    logic   wr_last;
    logic   rd_last;
    logic   rd_ack;
    logic   mem_we;

    word_t  mem [MEM_DEPTH];

    // only frames with our start code and id get a response
    assign frame_ok = (frame.start == START_CODE) && (frame.slave_id == SLAVE_ID);

    // a single transfer ends after one word, a burst on the word marked by last
    assign wr_last = !frame.burst || last_seen;
    assign rd_last = !frame.burst || last;

    // acknowledge counts only once the word has fully left the serializer
    assign rd_ack = valid && !rd_busy &&
                    ((state == ST_RD_SEND) || (state == ST_RD_ACK));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= ST_IDLE;
            addr  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // the first 1 on control opens the start code
                    if (control) begin
                        state <= ST_FRAME;
                    end
                end
                ST_FRAME: begin
                    if (frame_done) begin
                        state <= ST_CHECK;
                    end
                end
                ST_CHECK: begin
                    if (frame_ok) begin
                        addr  <= frame.addr;
                        state <= frame.write ? ST_WRITE : ST_RD_FETCH;
                    end else begin
                        state <= ST_IDLE;
                    end
                end
                ST_WRITE: begin
                    if (wr_done) begin
                        addr <= addr + 1'b1;
                        if (wr_last) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                ST_RD_FETCH: begin
                    state <= ST_RD_SEND;
                end
                ST_RD_SEND, ST_RD_ACK: begin
                    if (rd_ack) begin
                        if (rd_last) begin
                            state <= ST_IDLE;
                        end else begin
                            addr  <= addr + 1'b1;
                            state <= ST_RD_FETCH;
                        end
                    end else if (!rd_busy) begin
                        // wait here as long as the master holds off
                        state <= ST_RD_ACK;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // last may already be up on the first bit of the next word
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            last_seen <= 1'b0;
        end else if (state == ST_CHECK) begin
            last_seen <= 1'b0;
        end else if (wr_done) begin
            last_seen <= wr_shift && last;
        end else if (wr_shift && last) begin
            last_seen <= 1'b1;
        end
    end

    // word is complete in the deserializer while wr_done is high
    assign mem_we = (state == ST_WRITE) && wr_done;

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[addr] <= wr_word;
        end
    end

    assign rd_word = mem[addr];

    // bit enables for the two deserializers
    assign frame_shift = ((state == ST_IDLE) && control) ||
                         ((state == ST_FRAME) && !frame_done);
    assign wr_shift    = (state == ST_WRITE) && valid;

    assign rd_load = (state == ST_RD_FETCH);

    // high through a write, and while a read word is on rd
    assign ready = (state == ST_WRITE) || rd_busy;

endmodule

// File: hw/word_serializer.sv
`timescale 1ns/10ps
/*
 * parallel to serial shift register for read data
 * sends one word msb first, busy while the bits go out
 */
module word_serializer (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    load,
    input  serial_slave_pkg::word_t word,
    output logic                    bit_out,
    output logic                    busy
);
    import serial_slave_pkg::*;

    word_t                         shreg;
    logic [$clog2(DATA_WIDTH)-1:0] bit_cnt;
    logic                          cnt_last;

    assign cnt_last = (bit_cnt == DATA_WIDTH - 1);

    // capture on load, then move the next bit up to the msb each cycle
    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= word;
        end else if (busy) begin
            shreg <= {shreg[DATA_WIDTH-2:0], 1'b0};
        end
    end

    // busy covers exactly DATA_WIDTH cycles after the load
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
        end else if (load) begin
            busy    <= 1'b1;
            bit_cnt <= '0;
        end else if (busy) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (cnt_last) begin
                busy <= 1'b0;
            end
        end
    end

    // line stays low between words
    assign bit_out = busy & shreg[DATA_WIDTH-1];

endmodule

// File: project.f
hw/serial_slave_pkg.sv
hw/serial_deserializer.sv
hw/word_serializer.sv
hw/slave_controller.sv
hw/serial_slave_top.sv
sim/serial_slave_asserts.sv
sim/tb_serial_slave.sv

// File: sim/serial_slave_asserts.sv
`timescale 1ns/10ps
/*
 * concurrent protocol assertions on the slave bus lines,
 * bound to the top level of the serial bus slave
 */
module serial_slave_asserts (
    input logic                       clk,
    input logic                       rstN,
    input serial_slave_pkg::bus_in_t  bus_in,
    input serial_slave_pkg::bus_out_t bus_out
);

    // number of failed assertion checks
    int fail_count = 0;

    // slave outputs stay quiet while reset is applied
    reset_quiet: assert property (
        @(posedge clk) !rstN |-> (!bus_out.ready && !bus_out.rd)
    ) else begin
        $error("ready or rd high during reset");
        fail_count++;
    end

    ready_known: assert property (
        @(posedge clk) disable iff (!rstN) !$isunknown(bus_out.ready)
    ) else begin
        $error("ready is unknown after reset");
        fail_count++;
    end

    // a frame only starts while the slave is idle, so ready is low then
    ready_not_in_frame: assert property (
        @(posedge clk) disable iff (!rstN) !(bus_out.ready && bus_in.control)
    ) else begin
        $error("ready high while control is high");
        fail_count++;
    end

endmodule

bind serial_slave_top serial_slave_asserts u_asserts (
    .clk     (clk),
    .rstN    (rstN),
    .bus_in  (bus_in),
    .bus_out (bus_out)
);

// File: sim/tb_serial_slave.sv
`timescale 1ns/10ps
/*
 * testbench of the serial bus slave
 * clock, reset, bus driver tasks, transaction table,
 * reference memory and value checks
 */
module tb_serial_slave;
    import serial_slave_pkg::*;

    localparam sid_t DUT_ID       = 2'd1;
    localparam int   NUM_ROWS     = 12;
    localparam int   WAIT_LIMIT   = 40;
    localparam int   QUIET_CYCLES = 30;

    // one row of the transaction table
    typedef struct packed {
        logic       write;
        sid_t       slave_id;
        logic [2:0] start;
        logic       burst;
        addr_t      addr;
        logic [4:0] count;
        logic [3:0] ack_delay;
    } txn_t;

    logic        clk;
    logic        rstN;
    bus_in_t     bus_in;
    bus_out_t    bus_out;
    txn_t        rows [NUM_ROWS];
    word_t       ref_mem [MEM_DEPTH];
    logic [31:0] rng_state;
    int          errors;
    int          checks;
    logic        aborted;

    serial_slave_top #(
        .SLAVE_ID (DUT_ID)
    ) i_dut (
        .clk     (clk),
        .rstN    (rstN),
        .bus_in  (bus_in),
        .bus_out (bus_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // inputs change and outputs are sampled 5 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #5;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic wait_ready(input logic level, input string what);
        int n;
        n = 0;
        while (bus_out.ready !== level && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (bus_out.ready !== level) begin
            errors++;
            aborted = 1'b1;
            $display("timeout: ready did not go to %0d during %s", level, what);
        end
    endtask

    task automatic send_frame(input txn_t t);
        cmd_frame_t f;
        f = {t.start, t.slave_id, t.write, t.burst, t.addr};
        for (int i = CMD_BITS - 1; i >= 0; i--) begin
            bus_in.control = f[i];
            tick();
        end
        bus_in.control = 1'b0;
    endtask

    task automatic write_words(input txn_t t);
        word_t w;
        addr_t a;
        a = t.addr;
        wait_ready(1'b1, "write start");
        for (int k = 0; k < t.count && !aborted; k++) begin
            rng_state = xorshift(rng_state);
            w = rng_state[DATA_WIDTH-1:0];
            ref_mem[a] = w;
            a = a + 1'b1;
            // words go back to back, last marks every bit of the final one
            for (int b = DATA_WIDTH - 1; b >= 0; b--) begin
                check_value("ready", 1, bus_out.ready);
                bus_in.valid = 1'b1;
                bus_in.wd    = w[b];
                bus_in.last  = t.burst && (k == t.count - 1);
                tick();
            end
        end
        bus_in.valid = 1'b0;
        bus_in.wd    = 1'b0;
        bus_in.last  = 1'b0;
        if (!aborted) begin
            wait_ready(1'b0, "write end");
        end
    endtask

    task automatic read_words(input txn_t t);
        word_t got;
        addr_t a;
        a = t.addr;
        for (int k = 0; k < t.count && !aborted; k++) begin
            wait_ready(1'b1, "read word");
            if (!aborted) begin
                for (int b = DATA_WIDTH - 1; b >= 0; b--) begin
                    check_value("ready", 1, bus_out.ready);
                    got[b] = bus_out.rd;
                    tick();
                end
                check_value("rd word", ref_mem[a], got);
                a = a + 1'b1;
                // master holds off the acknowledge
                repeat (t.ack_delay) begin
                    check_value("ready", 0, bus_out.ready);
                    tick();
                end
                check_value("ready", 0, bus_out.ready);
                bus_in.valid = 1'b1;
                bus_in.last  = (k == t.count - 1);
                tick();
                bus_in.valid = 1'b0;
                bus_in.last  = 1'b0;
            end
        end
    endtask

    task automatic expect_silence();
        repeat (QUIET_CYCLES) begin
            check_value("ready", 0, bus_out.ready);
            check_value("rd", 0, bus_out.rd);
            tick();
        end
    endtask

    task automatic run_row(input txn_t t);
        send_frame(t);
        if (t.slave_id != DUT_ID || t.start != 3'b111) begin
            expect_silence();
        end else if (t.write) begin
            write_words(t);
        end else begin
            read_words(t);
        end
        repeat (2) tick();
    endtask

    // write, id, start, burst, addr, count, ack delay
    task automatic fill_table();
        rows[0]  = '{1'b1, 2'd1, 3'b111, 1'b0, 4'd3,  5'd1, 4'd0};
        rows[1]  = '{1'b0, 2'd1, 3'b111, 1'b0, 4'd3,  5'd1, 4'd0};
        rows[2]  = '{1'b1, 2'd1, 3'b111, 1'b1, 4'd14, 5'd4, 4'd0};
        rows[3]  = '{1'b0, 2'd1, 3'b111, 1'b1, 4'd14, 5'd4, 4'd0};
        rows[4]  = '{1'b1, 2'd2, 3'b111, 1'b0, 4'd3,  5'd1, 4'd0};
        rows[5]  = '{1'b1, 2'd1, 3'b101, 1'b1, 4'd0,  5'd2, 4'd0};
        rows[6]  = '{1'b0, 2'd2, 3'b111, 1'b0, 4'd14, 5'd1, 4'd0};
        rows[7]  = '{1'b0, 2'd1, 3'b111, 1'b0, 4'd3,  5'd1, 4'd0};
        rows[8]  = '{1'b0, 2'd1, 3'b111, 1'b1, 4'd15, 5'd3, 4'd6};
        rows[9]  = '{1'b1, 2'd1, 3'b111, 1'b1, 4'd7,  5'd3, 4'd0};
        rows[10] = '{1'b0, 2'd1, 3'b111, 1'b1, 4'd7,  5'd3, 4'd3};
        rows[11] = '{1'b0, 2'd1, 3'b110, 1'b0, 4'd7,  5'd1, 4'd0};
    endtask

    initial begin
        errors    = 0;
        checks    = 0;
        aborted   = 1'b0;
        rng_state = 32'd71;
        rstN      = 1'b1;
        bus_in    = '0;
        fill_table();
        #1;
        rstN = 1'b0;
        repeat (2) @(posedge clk);
        #5;
        rstN = 1'b1;
        // bus stays quiet over idle cycles
        repeat (4) begin
            check_value("ready", 0, bus_out.ready);
            check_value("rd", 0, bus_out.rd);
            tick();
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (!aborted) begin
                run_row(rows[i]);
            end
        end
        errors = errors + i_dut.u_asserts.fail_count;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
